//--- common/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

////////////////////
// Field widths, fixed by RV32I

`define XLEN        32          // Instruction and immediate width
`define REG_ADDR_W  5           // x0..x31
`define OPCODE_W    7           // inst[6:0]
`define FUNCT3_W    3           // inst[14:12]
`define FUNCT7_W    7           // inst[31:25]

////////////////////
// funct3 for R-type and I-type arithmetic
// The immediate forms share the register forms' encoding

`define FUNCT3_ADD_SUB  3'b000  // ADD, SUB, ADDI
`define FUNCT3_SLL      3'b001  // SLL, SLLI
`define FUNCT3_SLT      3'b010  // SLT, SLTI
`define FUNCT3_SLTU     3'b011  // SLTU, SLTIU
`define FUNCT3_XOR      3'b100  // XOR, XORI
`define FUNCT3_SRL_SRA  3'b101  // SRL, SRA, SRLI, SRAI
`define FUNCT3_OR       3'b110  // OR, ORI
`define FUNCT3_AND      3'b111  // AND, ANDI

// Loads
`define FUNCT3_LB       3'b000
`define FUNCT3_LH       3'b001
`define FUNCT3_LW       3'b010
`define FUNCT3_LBU      3'b100
`define FUNCT3_LHU      3'b101

// Stores
`define FUNCT3_SB       3'b000
`define FUNCT3_SH       3'b001
`define FUNCT3_SW       3'b010

// Branches, 010 and 011 undefined
`define FUNCT3_BEQ      3'b000
`define FUNCT3_BNE      3'b001
`define FUNCT3_BLT      3'b100
`define FUNCT3_BGE      3'b101
`define FUNCT3_BLTU     3'b110
`define FUNCT3_BGEU     3'b111

////////////////////
// funct7

`define FUNCT7_BASE     7'b0000000  // Plain op, and SLLI/SRLI
`define FUNCT7_ALT      7'b0100000  // SUB, SRA, SRAI

`define HALT_INST       32'h00100073  // EBREAK encoding used as HALT

`endif

//--- common/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_consts.svh"

package rv_decode_pkg;

    ////////////////////
    // Encodings

    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE  = 7'b0110011,   // Register-register ALU
        OP_ITYPE  = 7'b0010011,   // Register-immediate ALU
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'b00000,
        ALU_SUB  = 5'b00010,
        ALU_SLT  = 5'b00100,
        ALU_SLTU = 5'b00101,
        ALU_AND  = 5'b01001,
        ALU_OR   = 5'b01010,
        ALU_XOR  = 5'b01011,
        ALU_SLL  = 5'b01110,
        ALU_SRL  = 5'b01111,
        ALU_SRA  = 5'b10000,
        ALU_SRC0 = 5'b10001,      // Pass first operand
        ALU_SRC1 = 5'b10010,      // Pass second operand
        ALU_NONE = 5'b11111       // No valid ALU op
    } alu_op_e;

    typedef enum logic [3:0] {
        DMEM_NONE = 4'd0,
        DMEM_LW   = 4'd1,
        DMEM_LH   = 4'd2,
        DMEM_LB   = 4'd3,
        DMEM_LHU  = 4'd4,
        DMEM_LBU  = 4'd5,
        DMEM_SW   = 4'd9,         // Bit 3 marks a store
        DMEM_SH   = 4'd10,
        DMEM_SB   = 4'd11
    } dmem_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_PC4  = 2'd2,
        WB_ZERO = 2'd3
    } wb_sel_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_BEQ  = 4'd1,
        BR_BNE  = 4'd2,
        BR_BLT  = 4'd3,
        BR_BGE  = 4'd4,
        BR_BLTU = 4'd5,
        BR_BGEU = 4'd6,
        BR_JALR = 4'd8,           // Bit 3 marks an unconditional jump
        BR_JAL  = 4'd9
    } br_type_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_SHIFT,                // shamt field of SLLI/SRLI/SRAI
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    ////////////////////
    // Decode result

    typedef struct packed {
        alu_op_e                 alu_op;
        logic [`REG_ADDR_W-1:0]  rf_ra0;
        logic [`REG_ADDR_W-1:0]  rf_ra1;
        logic [`REG_ADDR_W-1:0]  rf_wa;
        logic                    rf_we;
        logic                    alu_src0_sel;   // 1 selects PC
        logic                    alu_src1_sel;   // 1 selects immediate
        dmem_e                   dmem_access;
        wb_sel_e                 rf_wd_sel;
        br_type_e                br_type;
        logic                    halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                   ctrl;
        logic [`XLEN-1:0]        imm;
    } decoded_t;

endpackage

`default_nettype wire

//--- decoder_top.f
+incdir+common
common/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/ctrl_decode.sv
rtl/decoder_top.sv
sim/tb_decoder_top.sv

//--- rtl/ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module ctrl_decode
    import rv_decode_pkg::*;
(
    input  logic [`XLEN-1:0] inst,
    output ctrl_t            ctrl,
    output imm_fmt_e         imm_fmt
);

    opcode_e               opcode;
    logic [`FUNCT3_W-1:0]  funct3;
    logic [`FUNCT7_W-1:0]  funct7;
    logic                  f7_base;     // funct7 all zero
    logic                  f7_alt;      // funct7 with bit 30 set
    logic                  alt_ok;      // funct3 that allows the alternate funct7
    logic                  f7_valid;

    assign opcode   = opcode_e'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign f7_base  = (funct7 == `FUNCT7_BASE);
    assign f7_alt   = (funct7 == `FUNCT7_ALT);
    assign alt_ok   = (funct3 == `FUNCT3_ADD_SUB) || (funct3 == `FUNCT3_SRL_SRA);
    assign f7_valid = f7_base || (f7_alt && alt_ok);

    always_comb
    begin
        ////////////////////
        // Defaults, the common ALU register case
        ctrl.halt         = (inst == `HALT_INST);
        ctrl.rf_ra0       = inst[19:15];
        ctrl.rf_ra1       = inst[24:20];
        ctrl.rf_wa        = inst[11:7];
        ctrl.rf_we        = 1'b1;
        ctrl.alu_src0_sel = 1'b0;
        ctrl.alu_src1_sel = 1'b0;
        ctrl.alu_op       = ALU_NONE;
        ctrl.dmem_access  = DMEM_NONE;
        ctrl.rf_wd_sel    = WB_ALU;
        ctrl.br_type      = BR_NONE;
        imm_fmt           = IMM_NONE;

        ////////////////////
        // Opcode decode
        case (opcode)
            OP_RTYPE:
            begin
                case (funct3)                               // Both operands from registers
                    `FUNCT3_ADD_SUB:
                        if (f7_alt)
                            ctrl.alu_op = ALU_SUB;
                        else
                            ctrl.alu_op = ALU_ADD;
                    `FUNCT3_SRL_SRA:
                        if (f7_alt)
                            ctrl.alu_op = ALU_SRA;
                        else
                            ctrl.alu_op = ALU_SRL;
                    `FUNCT3_SLL:  ctrl.alu_op = ALU_SLL;
                    `FUNCT3_SLT:  ctrl.alu_op = ALU_SLT;
                    `FUNCT3_SLTU: ctrl.alu_op = ALU_SLTU;
                    `FUNCT3_XOR:  ctrl.alu_op = ALU_XOR;
                    `FUNCT3_OR:   ctrl.alu_op = ALU_OR;
                    default:      ctrl.alu_op = ALU_AND;    // Only 3'b111 left
                endcase
                if (!f7_valid)
                begin
                    ctrl.alu_op = ALU_NONE;                 // Undefined funct7
                    ctrl.rf_we  = 1'b0;
                end
            end
            OP_ITYPE:
            begin
                ctrl.alu_src1_sel = 1'b1;                   // Immediate operand
                ctrl.rf_ra1       = '0;
                imm_fmt           = IMM_I;
                case (funct3)
                    `FUNCT3_ADD_SUB: ctrl.alu_op = ALU_ADD; // No SUBI, funct7 is immediate
                    `FUNCT3_SLL:
                    begin
                        imm_fmt     = IMM_SHIFT;
                        ctrl.alu_op = ALU_SLL;
                    end
                    `FUNCT3_SRL_SRA:
                    begin
                        imm_fmt = IMM_SHIFT;
                        if (f7_alt)
                            ctrl.alu_op = ALU_SRA;
                        else
                            ctrl.alu_op = ALU_SRL;
                    end
                    `FUNCT3_SLT:  ctrl.alu_op = ALU_SLT;
                    `FUNCT3_SLTU: ctrl.alu_op = ALU_SLTU;
                    `FUNCT3_XOR:  ctrl.alu_op = ALU_XOR;
                    `FUNCT3_OR:   ctrl.alu_op = ALU_OR;
                    default:      ctrl.alu_op = ALU_AND;
                endcase
                if ((imm_fmt == IMM_SHIFT) && !f7_valid)
                begin
                    ctrl.alu_op = ALU_NONE;                 // Bad shift funct7
                    ctrl.rf_we  = 1'b0;
                end
            end
            OP_LUI:
            begin
                ctrl.rf_ra0       = '0;
                ctrl.rf_ra1       = '0;
                ctrl.alu_op       = ALU_SRC1;               // Result is the immediate
                ctrl.alu_src1_sel = 1'b1;
                imm_fmt           = IMM_U;
            end
            OP_AUIPC:
            begin
                ctrl.rf_ra0       = '0;
                ctrl.rf_ra1       = '0;
                ctrl.alu_op       = ALU_ADD;                // PC + upper immediate
                ctrl.alu_src0_sel = 1'b1;
                ctrl.alu_src1_sel = 1'b1;
                imm_fmt           = IMM_U;
            end
            OP_LOAD:
            begin
                ctrl.rf_wd_sel    = WB_MEM;
                ctrl.rf_ra1       = '0;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;                // rs1 + offset
                imm_fmt           = IMM_I;
                case (funct3)
                    `FUNCT3_LW:  ctrl.dmem_access = DMEM_LW;
                    `FUNCT3_LH:  ctrl.dmem_access = DMEM_LH;
                    `FUNCT3_LB:  ctrl.dmem_access = DMEM_LB;
                    `FUNCT3_LHU: ctrl.dmem_access = DMEM_LHU;
                    `FUNCT3_LBU: ctrl.dmem_access = DMEM_LBU;
                    default:
                    begin
                        ctrl.rf_we  = 1'b0;
                        ctrl.alu_op = ALU_NONE;
                    end
                endcase
            end
            OP_STORE:
            begin
                ctrl.rf_we        = 1'b0;                   // Nothing written back
                ctrl.rf_wa        = '0;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;
                imm_fmt           = IMM_S;
                case (funct3)
                    `FUNCT3_SW: ctrl.dmem_access = DMEM_SW;
                    `FUNCT3_SH: ctrl.dmem_access = DMEM_SH;
                    `FUNCT3_SB: ctrl.dmem_access = DMEM_SB;
                    default:    ctrl.alu_op      = ALU_NONE;
                endcase
            end
            OP_JALR:
            begin
                ctrl.rf_wd_sel    = WB_PC4;                 // Link address
                ctrl.rf_ra1       = '0;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;                // Target rs1 + imm
                ctrl.br_type      = BR_JALR;
                imm_fmt           = IMM_I;
            end
            OP_JAL:
            begin
                ctrl.rf_wd_sel    = WB_PC4;
                ctrl.rf_ra0       = '0;
                ctrl.rf_ra1       = '0;
                ctrl.alu_src0_sel = 1'b1;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;                // Target PC + imm
                ctrl.br_type      = BR_JAL;
                imm_fmt           = IMM_J;
            end
            OP_BRANCH:
            begin
                ctrl.rf_we        = 1'b0;
                ctrl.rf_wa        = '0;
                ctrl.alu_src0_sel = 1'b1;
                ctrl.alu_src1_sel = 1'b1;
                ctrl.alu_op       = ALU_ADD;                // Branch target
                imm_fmt           = IMM_B;
                case (funct3)
                    `FUNCT3_BEQ:  ctrl.br_type = BR_BEQ;
                    `FUNCT3_BNE:  ctrl.br_type = BR_BNE;
                    `FUNCT3_BLT:  ctrl.br_type = BR_BLT;
                    `FUNCT3_BGE:  ctrl.br_type = BR_BGE;
                    `FUNCT3_BLTU: ctrl.br_type = BR_BLTU;
                    `FUNCT3_BGEU: ctrl.br_type = BR_BGEU;
                    default:      ctrl.alu_op  = ALU_NONE;
                endcase
            end
            default:
            begin
                ctrl.rf_we     = 1'b0;                      // Unknown opcode, HALT lands here
                ctrl.rf_wd_sel = WB_ZERO;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module decoder_top
    import rv_decode_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    output logic             out_valid,
    output decoded_t         decoded
);

    ctrl_t            ctrl_d;       // Combinational control decode
    imm_fmt_e         imm_fmt;
    logic [`XLEN-1:0] imm_d;
    ctrl_t            ctrl_q;       // Pipeline register, control half
    logic [`XLEN-1:0] imm_q;        // Pipeline register, immediate half

    ////////////////////
    // Decode, zero cycles

    ctrl_decode ctrl0 (
        .inst    (inst),
        .ctrl    (ctrl_d),
        .imm_fmt (imm_fmt)
    );

    imm_gen imm0 (
        .inst    (inst),
        .imm_fmt (imm_fmt),
        .imm     (imm_d)
    );

    ////////////////////
    // Output register, one cycle

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid     <= 1'b0;
            ctrl_q        <= '0;            // No write, access, branch or halt
            ctrl_q.alu_op <= ALU_NONE;
        end
        else
        begin
            out_valid <= inst_valid;
            if (inst_valid)
                ctrl_q <= ctrl_d;           // Hold last result when idle
        end
    end

    always_ff @(posedge clk)
    begin
        if (inst_valid)
            imm_q <= imm_d;
    end

    assign decoded = {ctrl_q, imm_q};

endmodule

`default_nettype wire

//--- rtl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  logic [`XLEN-1:0] inst,
    input  imm_fmt_e         imm_fmt,
    output logic [`XLEN-1:0] imm
);

    logic sign;                                 // inst[31], sign of every format but shift

    assign sign = inst[31];

    always_comb
    begin
        case (imm_fmt)
            IMM_I:
                imm = {{20{sign}}, inst[31:20]};
            IMM_SHIFT:
                imm = {{27{inst[24]}}, inst[24:20]};  // shamt, extended from bit 24
            IMM_S:
                imm = {{20{sign}}, inst[31:25], inst[11:7]};
            IMM_B:
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:
                imm = {inst[31:12], 12'b0};           // Upper 20 bits
            IMM_J:
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;                             // R-type and unknown
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -f sim.log
verilator --binary --timing -f decoder_top.f --top-module tb_decoder_top \
    && ./obj_dir/Vtb_decoder_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST PASS$" sim.log 2>/dev/null && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- sim/tb_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_consts.svh"

module tb_decoder_top
    import rv_decode_pkg::*;
();

    logic             clk;
    logic             reset;
    logic             inst_valid;
    logic [`XLEN-1:0] inst;
    logic             out_valid;
    decoded_t         decoded;

    string            names[$];             // Test table
    logic [31:0]      insts[$];
    logic             valids[$];
    decoded_t         exps[$];
    int               n_fixed;              // Rows before the random part
    int               watchdog_ns;
    logic [31:0]      seed;

    string            pend_name;            // Row waiting for its edge
    decoded_t         pend_exp;
    logic             pend_vld;
    logic             pend;

    // Non-shift I-type ops and branch types for random rows
    logic [2:0] i_f3 [6] = '{3'b000, 3'b010, 3'b011, 3'b100, 3'b110, 3'b111};
    alu_op_e    i_alu [6] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND};
    logic [2:0] b_f3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    br_type_e   b_br [6] = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};

    decoder_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .out_valid  (out_valid),
        .decoded    (decoded)
    );

    always #4 clk = ~clk;                   // 8 ns period

    ////////////////////
    // Instruction encoders

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Expected decode result, field by field
    function automatic decoded_t mk(input alu_op_e alu, input logic [4:0] ra0, ra1, wa,
                                    input logic we, s0, s1, input dmem_e dm,
                                    input wb_sel_e wb, input br_type_e br,
                                    input logic halt, input logic [31:0] imm);
        decoded_t d;
        d.ctrl.alu_op       = alu;
        d.ctrl.rf_ra0       = ra0;
        d.ctrl.rf_ra1       = ra1;
        d.ctrl.rf_wa        = wa;
        d.ctrl.rf_we        = we;
        d.ctrl.alu_src0_sel = s0;
        d.ctrl.alu_src1_sel = s1;
        d.ctrl.dmem_access  = dm;
        d.ctrl.rf_wd_sel    = wb;
        d.ctrl.br_type      = br;
        d.ctrl.halt         = halt;
        d.imm               = imm;
        return d;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [71:0] exp,
                               input logic [71:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    ////////////////////
    // Table building

    task automatic add_row(input string name, input logic [31:0] in, input logic vld,
                           input decoded_t exp);
        names.push_back(name);
        insts.push_back(in);
        valids.push_back(vld);
        exps.push_back(exp);
    endtask

    task automatic add_rtype(input string name, input logic [6:0] f7, input logic [2:0] f3,
                             input alu_op_e alu, input logic we);
        add_row(name, enc_r(f7, 5'd3, 5'd2, f3, 5'd1, OP_RTYPE), 1'b1,    // x1 = x2 op x3
                mk(alu, 5'd2, 5'd3, 5'd1, we, 1'b0, 1'b0, DMEM_NONE, WB_ALU, BR_NONE,
                   1'b0, 32'h0));
    endtask

    task automatic add_itype(input string name, input logic [11:0] imm, input logic [2:0] f3,
                             input alu_op_e alu, input logic we, input logic [31:0] exp_imm);
        add_row(name, enc_i(imm, 5'd2, f3, 5'd4, OP_ITYPE), 1'b1,
                mk(alu, 5'd2, 5'd0, 5'd4, we, 1'b0, 1'b1, DMEM_NONE, WB_ALU, BR_NONE,
                   1'b0, exp_imm));
    endtask

    task automatic add_load(input string name, input logic [2:0] f3, input dmem_e dm,
                            input alu_op_e alu, input logic we);
        add_row(name, enc_i(12'h010, 5'd6, f3, 5'd7, OP_LOAD), 1'b1,     // Offset 16
                mk(alu, 5'd6, 5'd0, 5'd7, we, 1'b0, 1'b1, dm, WB_MEM, BR_NONE,
                   1'b0, 32'h10));
    endtask

    task automatic add_store(input string name, input logic [2:0] f3, input dmem_e dm,
                             input alu_op_e alu);
        add_row(name, enc_s(12'hFF8, 5'd9, 5'd8, f3), 1'b1,               // Offset -8
                mk(alu, 5'd8, 5'd9, 5'd0, 1'b0, 1'b0, 1'b1, dm, WB_ALU, BR_NONE,
                   1'b0, 32'hFFFF_FFF8));
    endtask

    task automatic add_branch(input string name, input logic [2:0] f3, input br_type_e br,
                              input alu_op_e alu);
        add_row(name, enc_b(13'h1FF0, 5'd11, 5'd10, f3), 1'b1,           // Offset -16
                mk(alu, 5'd10, 5'd11, 5'd0, 1'b0, 1'b1, 1'b1, DMEM_NONE, WB_ALU, br,
                   1'b0, 32'hFFFF_FFF0));
    endtask

    // Inputs change but the register must keep the last result
    task automatic add_idle(input string name);
        add_row(name, enc_i(12'h7AB, 5'd6, 3'b000, 5'd5, OP_ITYPE), 1'b0, exps[$]);
    endtask

    task automatic build_table();
        add_rtype("add", 7'h00, 3'b000, ALU_ADD, 1'b1);
        add_rtype("sub", 7'h20, 3'b000, ALU_SUB, 1'b1);
        add_rtype("sll", 7'h00, 3'b001, ALU_SLL, 1'b1);
        add_rtype("slt", 7'h00, 3'b010, ALU_SLT, 1'b1);
        add_rtype("sltu", 7'h00, 3'b011, ALU_SLTU, 1'b1);
        add_rtype("xor", 7'h00, 3'b100, ALU_XOR, 1'b1);
        add_rtype("srl", 7'h00, 3'b101, ALU_SRL, 1'b1);
        add_rtype("sra", 7'h20, 3'b101, ALU_SRA, 1'b1);
        add_rtype("or", 7'h00, 3'b110, ALU_OR, 1'b1);
        add_rtype("and", 7'h00, 3'b111, ALU_AND, 1'b1);
        add_rtype("and_bad_f7", 7'h20, 3'b111, ALU_NONE, 1'b0);   // Alt funct7 not allowed
        add_rtype("add_bad_f7", 7'h01, 3'b000, ALU_NONE, 1'b0);
        add_itype("addi_neg", 12'hFFB, 3'b000, ALU_ADD, 1'b1, 32'hFFFF_FFFB);
        add_itype("andi_pos", 12'h7FF, 3'b111, ALU_AND, 1'b1, 32'h0000_07FF);
        add_itype("slli", {7'h00, 5'd3}, 3'b001, ALU_SLL, 1'b1, 32'h3);
        add_itype("srli", {7'h00, 5'd31}, 3'b101, ALU_SRL, 1'b1, 32'hFFFF_FFFF);
        add_itype("srai", {7'h20, 5'd17}, 3'b101, ALU_SRA, 1'b1, 32'hFFFF_FFF1);
        add_itype("slli_bad_f7", {7'h20, 5'd2}, 3'b001, ALU_NONE, 1'b0, 32'h2);
        add_itype("srli_bad_f7", {7'h01, 5'd4}, 3'b101, ALU_NONE, 1'b0, 32'h4);
        add_row("lui", {20'h12345, 5'd5, OP_LUI}, 1'b1,
                mk(ALU_SRC1, 5'd0, 5'd0, 5'd5, 1'b1, 1'b0, 1'b1, DMEM_NONE, WB_ALU, BR_NONE,
                   1'b0, 32'h1234_5000));
        add_row("auipc", {20'hFEDCB, 5'd5, OP_AUIPC}, 1'b1,
                mk(ALU_ADD, 5'd0, 5'd0, 5'd5, 1'b1, 1'b1, 1'b1, DMEM_NONE, WB_ALU, BR_NONE,
                   1'b0, 32'hFEDC_B000));
        add_load("lw", 3'b010, DMEM_LW, ALU_ADD, 1'b1);
        add_load("lh", 3'b001, DMEM_LH, ALU_ADD, 1'b1);
        add_load("lb", 3'b000, DMEM_LB, ALU_ADD, 1'b1);
        add_load("lhu", 3'b101, DMEM_LHU, ALU_ADD, 1'b1);
        add_load("lbu", 3'b100, DMEM_LBU, ALU_ADD, 1'b1);
        add_load("load_bad_f3", 3'b011, DMEM_NONE, ALU_NONE, 1'b0);
        add_store("sw", 3'b010, DMEM_SW, ALU_ADD);
        add_store("sh", 3'b001, DMEM_SH, ALU_ADD);
        add_store("sb", 3'b000, DMEM_SB, ALU_ADD);
        add_store("store_bad_f3", 3'b100, DMEM_NONE, ALU_NONE);
        add_branch("beq", 3'b000, BR_BEQ, ALU_ADD);
        add_branch("bne", 3'b001, BR_BNE, ALU_ADD);
        add_branch("blt", 3'b100, BR_BLT, ALU_ADD);
        add_branch("bge", 3'b101, BR_BGE, ALU_ADD);
        add_branch("bltu", 3'b110, BR_BLTU, ALU_ADD);
        add_branch("bgeu", 3'b111, BR_BGEU, ALU_ADD);
        add_branch("branch_bad_f3", 3'b010, BR_NONE, ALU_NONE);
        add_row("jal_pos", enc_j(21'h15ABC, 5'd1), 1'b1,
                mk(ALU_ADD, 5'd0, 5'd0, 5'd1, 1'b1, 1'b1, 1'b1, DMEM_NONE, WB_PC4, BR_JAL,
                   1'b0, 32'h0001_5ABC));
        add_row("jal_neg", enc_j(21'h1FFFFC, 5'd1), 1'b1,
                mk(ALU_ADD, 5'd0, 5'd0, 5'd1, 1'b1, 1'b1, 1'b1, DMEM_NONE, WB_PC4, BR_JAL,
                   1'b0, 32'hFFFF_FFFC));
        add_row("jalr", enc_i(12'h004, 5'd1, 3'b000, 5'd0, OP_JALR), 1'b1,
                mk(ALU_ADD, 5'd1, 5'd0, 5'd0, 1'b1, 1'b0, 1'b1, DMEM_NONE, WB_PC4, BR_JALR,
                   1'b0, 32'h4));
        add_row("halt", `HALT_INST, 1'b1,
                mk(ALU_NONE, 5'd0, 5'd1, 5'd0, 1'b0, 1'b0, 1'b0, DMEM_NONE, WB_ZERO, BR_NONE,
                   1'b1, 32'h0));
        add_idle("idle_hold_0");
        add_idle("idle_hold_1");
        add_row("unknown_op", enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0001111), 1'b1,
                mk(ALU_NONE, 5'd2, 5'd3, 5'd1, 1'b0, 1'b0, 1'b0, DMEM_NONE, WB_ZERO, BR_NONE,
                   1'b0, 32'h0));
        n_fixed = names.size();
    endtask

    // Alternating random I-type and B-type rows
    task automatic add_random(input int count);
        logic [31:0] r;
        logic [12:0] boff;
        int          idx;
        for (int k = 0; k < count; k++)
        begin
            r    = xorshift32(seed);
            seed = r;
            idx  = r[7:0] % 6;
            boff = {r[31:20], 1'b0};                        // Even branch offset
            if (k % 2 == 0)
                add_row($sformatf("rand_i_%0d", k),
                        enc_i(r[31:20], r[19:15], i_f3[idx], r[11:7], OP_ITYPE), 1'b1,
                        mk(i_alu[idx], r[19:15], 5'd0, r[11:7], 1'b1, 1'b0, 1'b1, DMEM_NONE,
                           WB_ALU, BR_NONE, 1'b0, {{20{r[31]}}, r[31:20]}));
            else
                add_row($sformatf("rand_b_%0d", k),
                        enc_b(boff, r[24:20], r[19:15], b_f3[idx]), 1'b1,
                        mk(ALU_ADD, r[19:15], r[24:20], 5'd0, 1'b0, 1'b1, 1'b1, DMEM_NONE,
                           WB_ALU, b_br[idx], 1'b0, {{19{boff[12]}}, boff}));
        end
    endtask

    ////////////////////
    // Stimulus and checking

    task automatic check_pending();
        if (pend)
        begin
            check_value(pend_name, 72'(pend_exp), 72'(decoded));
            check_value({pend_name, " out_valid"}, 72'(pend_vld), 72'(out_valid));
        end
    endtask

    // Check the previous row, then drive this one, all on the falling edge
    task automatic step(input string name, input logic [31:0] in, input logic vld,
                        input decoded_t exp);
        @(negedge clk);
        check_pending();
        inst       = in;
        inst_valid = vld;
        pend_name  = name;
        pend_exp   = exp;
        pend_vld   = vld;
        pend       = 1'b1;
    endtask

    task automatic check_reset_state();
        check_value("reset out_valid", 72'(1'b0), 72'(out_valid));
        check_value("reset rf_we", 72'(1'b0), 72'(decoded.ctrl.rf_we));
        check_value("reset halt", 72'(1'b0), 72'(decoded.ctrl.halt));
        check_value("reset dmem_access", 72'(DMEM_NONE), 72'(decoded.ctrl.dmem_access));
        check_value("reset br_type", 72'(BR_NONE), 72'(decoded.ctrl.br_type));
    endtask

    initial
    begin
        clk        = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pend       = 1'b0;
        seed       = 32'h742d;
        build_table();
        add_random(64);
        watchdog_ns = 4 * (16 + n_fixed + 64 + 10) * 8;

        fork
            begin
                #(watchdog_ns);
                $display("Watchdog expired, the decode tests did not finish in time");
                $display("TEST FAIL");
                $fatal(1, "Timeout after %0d ns", watchdog_ns);
            end
        join_none

        // Valid ADD, store, branch and HALT presented while reset is held
        for (int i = 0; i < 16; i++)
        begin
            @(negedge clk);
            if (i > 0)
                check_reset_state();
            inst_valid = 1'b1;
            case (i / 4)
                0:       inst = enc_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd1, OP_RTYPE);  // Writes rd
                1:       inst = enc_s(12'h004, 5'd9, 5'd8, 3'b010);                // Store
                2:       inst = enc_b(13'h0010, 5'd11, 5'd10, 3'b000);             // Branch
                default: inst = `HALT_INST;
            endcase
            if (i == 15)
            begin
                reset      = 1'b0;
                inst_valid = 1'b0;
            end
        end

        for (int n = 0; n < names.size(); n++)
            step(names[n], insts[n], valids[n], exps[n]);
        @(negedge clk);
        check_pending();                    // Last row

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire
